//--- verilog/positPkg.sv
// Posit number format constants and the field widths derived from them

package positPkg;

  // ==========================================================
  // Format
  // ==========================================================

  // Total posit width in bits
  localparam int PSTWID = 16;

  // Number of exponent bits, so each regime step is worth 2^(2^ES)
  localparam int ES = 1;

  // ==========================================================
  // Derived field widths
  // ==========================================================

  // Regime run counter, wide enough for a run of 0 to 15 bits
  localparam int RS = 4;

  // Widest fraction field left after sign, a two bit regime and the exponent
  localparam int FRACWID = PSTWID - 4;

  // NaR is the sign bit alone with every other bit clear
  localparam logic [PSTWID-1:0] NARWORD = {1'b1, {(PSTWID - 1){1'b0}}};

endpackage

//--- verilog/quirePkg.sv
// Quire fixed-point format, conversion step size, operation codes and FSM encodings

package quirePkg;

  // Quire word width, wraps modulo 2^QWID on accumulation
  localparam int QWID = 128;

  // A quire holds the value times 2^QFRAC in two's complement
  localparam int QFRAC = 56;

  // Signed scale width, covers 2 * regime + exponent with room to spare
  localparam int SCALEWID = 7;

  // Largest shift performed by the converter in one cycle
  localparam int SHIFTSTEP = 4;
  localparam int STEPWID = $clog2(SHIFTSTEP + 1);

  // Client operation codes
  localparam logic OPCLEAR = 1'b0;
  localparam logic OPACCUM = 1'b1;

  // ==========================================================
  // FSM state encodings, IDLE is shared by both machines
  // ==========================================================
  localparam logic [2:0] IDLE       = 3'd0;
  localparam logic [2:0] LOAD       = 3'd1;
  localparam logic [2:0] SHIFTLEFT  = 3'd2;
  localparam logic [2:0] SHIFTRIGHT = 3'd3;
  localparam logic [2:0] FINISH     = 3'd4;
  localparam logic [2:0] CLEARING   = 3'd1;
  localparam logic [2:0] CONVERTING = 3'd2;
  localparam logic [2:0] ACKED      = 3'd3;
  localparam logic [2:0] RELEASE    = 3'd4;

endpackage

//--- verilog/positDecompose.sv
// Registered posit decoder producing sign, regime, exponent, significand, zero and NaR
`timescale 1ns/1ps

module positDecompose (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         decStart,
  input  logic [positPkg::PSTWID-1:0]  posit,
  output logic                         sgn,
  output logic                         rgs,
  output logic [positPkg::RS-1:0]      rgm,
  output logic [positPkg::ES-1:0]      expo,
  output logic [positPkg::FRACWID:0]   sig,
  output logic                         zer,
  output logic                         inf,
  output logic                         fieldsValid
);

  logic [positPkg::PSTWID-1:0]  absP;
  logic [positPkg::PSTWID-1:0]  rest;
  logic [positPkg::RS-1:0]      runLen;
  logic                         runOpen;
  logic                         runBit;

  // ==========================================================
  // Combinational field extraction
  // ==========================================================

  // Negative posits are decoded from their two's complement
  assign absP   = posit[positPkg::PSTWID-1] ? -posit : posit;
  assign runBit = absP[positPkg::PSTWID-2];

  // Count identical bits from just below the sign until the first change
  always_comb begin
    runLen  = '0;
    runOpen = 1'b1;
    for (int i = positPkg::PSTWID - 2; i >= 0; i--) begin
      if (runOpen && (absP[i] == runBit)) begin
        runLen = runLen + 1'b1;
      end else begin
        runOpen = 1'b0;
      end
    end
  end

  // Drop sign, regime run and terminator so exponent sits at the top
  // Bits shifted past the end come back as zeros, which fills short fields
  assign rest = absP << (runLen + 2);

  // ==========================================================
  // Field registers
  // ==========================================================

  // Payload only moves on a start strobe
  always_ff @(posedge clk) begin
    if (decStart) begin
      sgn  <= posit[positPkg::PSTWID-1];
      rgs  <= runBit;
      // A run of ones of length k means regime k-1, zeros mean -k
      rgm  <= runBit ? runLen - 1'b1 : runLen;
      expo <= rest[positPkg::PSTWID-1 -: positPkg::ES];
      // Hidden one above the left-aligned fraction
      sig  <= {1'b1, rest[positPkg::PSTWID-1-positPkg::ES -: positPkg::FRACWID]};
      zer  <= (posit == '0);
      inf  <= (posit == positPkg::NARWORD);
    end
  end

  // Fields are valid exactly one cycle after the start strobe
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      fieldsValid <= 1'b0;
    end else begin
      fieldsValid <= decStart;
    end
  end

  // The controller issues one decode per transaction
  validIsPulse: assert property (@(posedge clk) disable iff (!arstN)
    fieldsValid |=> !fieldsValid);

endmodule

//--- verilog/positToQuire.sv
// Multi-cycle converter from decoded posit fields to the exact quire fixed-point value
`timescale 1ns/1ps

module positToQuire (
  input  logic                               clk,
  input  logic                               arstN,
  input  logic                               fieldsValid,
  input  logic                               sgn,
  input  logic                               rgs,
  input  logic [positPkg::RS-1:0]            rgm,
  input  logic [positPkg::ES-1:0]            expo,
  input  logic [positPkg::FRACWID:0]         sig,
  input  logic                               zer,
  input  logic                               inf,
  output logic [quirePkg::QWID-1:0]          qValue,
  output logic                               qNar,
  output logic                               convDone
);

  logic [2:0]                            state;
  logic [quirePkg::QWID-1:0]             qAcc;
  logic signed [quirePkg::SCALEWID-1:0]  remScale;
  logic                                  qSgn;

  logic signed [quirePkg::SCALEWID-1:0]  regVal;
  logic signed [quirePkg::SCALEWID-1:0]  loadScale;
  logic [quirePkg::SCALEWID-1:0]         absRem;
  logic [quirePkg::STEPWID-1:0]          stepAmt;
  logic [quirePkg::SCALEWID-1:0]         stepExt;

  // ==========================================================
  // Scale and step size
  // ==========================================================

  // Signed scale is regime * 2^ES plus the exponent
  always_comb begin
    regVal = $signed({{(quirePkg::SCALEWID - positPkg::RS){1'b0}}, rgm});
    if (!rgs) begin
      regVal = -regVal;
    end
    loadScale = (regVal <<< positPkg::ES)
              + $signed({{(quirePkg::SCALEWID - positPkg::ES){1'b0}}, expo});
  end

  // Shift by the full step or by whatever scale is left, whichever is smaller
  always_comb begin
    absRem = remScale[quirePkg::SCALEWID-1] ? -remScale : remScale;
    if (absRem > quirePkg::SHIFTSTEP) begin
      stepAmt = quirePkg::SHIFTSTEP[quirePkg::STEPWID-1:0];
    end else begin
      stepAmt = absRem[quirePkg::STEPWID-1:0];
    end
    stepExt = {{(quirePkg::SCALEWID - quirePkg::STEPWID){1'b0}}, stepAmt};
  end

  // ==========================================================
  // State machine
  // ==========================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= quirePkg::IDLE;
    end else begin
      case (state)
        quirePkg::LOAD: begin
          // Zero and NaR carry no magnitude, so they skip shifting
          if (zer || inf) begin
            state <= quirePkg::FINISH;
          end else if (loadScale > 0) begin
            state <= quirePkg::SHIFTLEFT;
          end else if (loadScale < 0) begin
            state <= quirePkg::SHIFTRIGHT;
          end else begin
            state <= quirePkg::FINISH;
          end
        end
        quirePkg::SHIFTLEFT, quirePkg::SHIFTRIGHT: begin
          // Last step consumes the remainder
          if (absRem <= quirePkg::SHIFTSTEP) begin
            state <= quirePkg::FINISH;
          end
        end
        quirePkg::FINISH: state <= quirePkg::IDLE;
        default: ;
      endcase
      // New fields abort any conversion in flight
      if (fieldsValid) begin
        state <= quirePkg::LOAD;
      end
    end
  end

  // Magnitude datapath
  always_ff @(posedge clk) begin
    case (state)
      quirePkg::LOAD: begin
        qSgn     <= sgn;
        qNar     <= inf;
        remScale <= loadScale;
        // Hidden bit lands on quire bit QFRAC, the binary point of the quire
        if (zer || inf) begin
          qAcc <= '0;
        end else begin
          qAcc <= {{(quirePkg::QWID - positPkg::FRACWID - 1){1'b0}}, sig}
                  << (quirePkg::QFRAC - positPkg::FRACWID);
        end
      end
      quirePkg::SHIFTLEFT: begin
        qAcc     <= qAcc << stepAmt;
        remScale <= remScale - stepExt;
      end
      quirePkg::SHIFTRIGHT: begin
        qAcc     <= qAcc >> stepAmt;
        remScale <= remScale + stepExt;
      end
      default: ;
    endcase
  end

  // Sign is applied in the finish cycle, while convDone is high
  assign qValue   = qSgn ? -qAcc : qAcc;
  assign convDone = (state == quirePkg::FINISH);

  // The controller never starts a decode while a result is being delivered
  doneNotWithLoad: assert property (@(posedge clk) disable iff (!arstN)
    !(convDone && fieldsValid));

  // Shifting stops exactly at zero and never overshoots into the other sign
  leftKeepsSign: assert property (@(posedge clk) disable iff (!arstN)
    (state == quirePkg::SHIFTLEFT) |-> (remScale > 0));
  rightKeepsSign: assert property (@(posedge clk) disable iff (!arstN)
    (state == quirePkg::SHIFTRIGHT) |-> (remScale < 0));

endmodule

//--- verilog/quireAccumulator.sv
// Running quire register with clear, modular add and a sticky NaR flag
`timescale 1ns/1ps

module quireAccumulator (
  input  logic                        clk,
  input  logic                        arstN,
  input  logic                        accClear,
  input  logic                        convDone,
  input  logic [quirePkg::QWID-1:0]   qValue,
  input  logic                        qNar,
  output logic [quirePkg::QWID-1:0]   quire,
  output logic                        nar
);

  // ==========================================================
  // Accumulator register
  // ==========================================================

  // Updates land on the edge that samples the strobe, so the controller
  // can raise ack in the following cycle with a settled sum
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      quire <= '0;
      nar   <= 1'b0;
    end else if (accClear) begin
      // Clear restarts both the sum and the NaR history
      quire <= '0;
      nar   <= 1'b0;
    end else if (convDone) begin
      if (qNar) begin
        // NaR poisons the result but the sum itself is kept
        nar <= 1'b1;
      end else begin
        // No overflow detection, the sum simply wraps
        quire <= quire + qValue;
      end
    end
  end

  // The controller only ever has one of the two operations in flight
  clearNotWithAdd: assert property (@(posedge clk) disable iff (!arstN)
    !(accClear && convDone));

endmodule

//--- verilog/reqAckCtrl.sv
// Four-phase req/ack controller sequencing decode, conversion and accumulation
`timescale 1ns/1ps

module reqAckCtrl (
  input  logic  clk,
  input  logic  arstN,
  input  logic  req,
  input  logic  op,
  output logic  ack,
  output logic  decStart,
  output logic  accClear,
  input  logic  convDone
);

  logic [2:0] state;

  // ==========================================================
  // Handshake FSM
  // ==========================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= quirePkg::IDLE;
      ack      <= 1'b0;
      decStart <= 1'b0;
      accClear <= 1'b0;
    end else begin
      // Strobes are single-cycle unless set below
      decStart <= 1'b0;
      accClear <= 1'b0;
      case (state)
        quirePkg::IDLE: begin
          // Only a fresh request is looked at, with ack already low
          if (req) begin
            unique case (op)
              quirePkg::OPCLEAR: begin
                accClear <= 1'b1;
                state    <= quirePkg::CLEARING;
              end
              quirePkg::OPACCUM: begin
                decStart <= 1'b1;
                state    <= quirePkg::CONVERTING;
              end
            endcase
          end
        end
        quirePkg::CLEARING: begin
          // Accumulator clears on this edge, ack is high two cycles after req was taken
          ack   <= 1'b1;
          state <= quirePkg::ACKED;
        end
        quirePkg::CONVERTING: begin
          // Sum is updated on the same edge, so ack follows convDone by one cycle
          if (convDone) begin
            ack   <= 1'b1;
            state <= quirePkg::ACKED;
          end
        end
        quirePkg::ACKED: begin
          // Client stalls by holding req, nothing moves meanwhile
          if (!req) begin
            ack   <= 1'b0;
            state <= quirePkg::RELEASE;
          end
        end
        quirePkg::RELEASE: state <= quirePkg::IDLE;
        default: state <= quirePkg::IDLE;
      endcase
    end
  end

  // Ack is an answer to a request that is still being held
  ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
    $rose(ack) |-> (req && $past(req)));

endmodule

//--- verilog/positQuireTop.sv
// Posit to quire accumulate unit with a four-phase req/ack client interface
`timescale 1ns/1ps

module positQuireTop (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         req,
  input  logic                         op,
  input  logic [positPkg::PSTWID-1:0]  posit,
  output logic                         ack,
  output logic [quirePkg::QWID-1:0]    quire,
  output logic                         nar
);

  // Controller strobes
  logic                          decStart;
  logic                          accClear;

  // Decoded posit fields
  logic                          sgn;
  logic                          rgs;
  logic [positPkg::RS-1:0]       rgm;
  logic [positPkg::ES-1:0]       expo;
  logic [positPkg::FRACWID:0]    sig;
  logic                          zer;
  logic                          inf;
  logic                          fieldsValid;

  // Converted value for the accumulator
  logic [quirePkg::QWID-1:0]     qValue;
  logic                          qNar;
  logic                          convDone;

  // ==========================================================
  // Datapath chain: control, decode, convert, accumulate
  // ==========================================================
  reqAckCtrl i_reqAckCtrl (
    .clk(clk), .arstN(arstN), .req(req), .op(op), .ack(ack),
    .decStart(decStart), .accClear(accClear), .convDone(convDone)
  );

  positDecompose i_positDecompose (
    .clk(clk), .arstN(arstN), .decStart(decStart), .posit(posit),
    .sgn(sgn), .rgs(rgs), .rgm(rgm), .expo(expo), .sig(sig),
    .zer(zer), .inf(inf), .fieldsValid(fieldsValid)
  );

  positToQuire i_positToQuire (
    .clk(clk), .arstN(arstN), .fieldsValid(fieldsValid),
    .sgn(sgn), .rgs(rgs), .rgm(rgm), .expo(expo), .sig(sig),
    .zer(zer), .inf(inf),
    .qValue(qValue), .qNar(qNar), .convDone(convDone)
  );

  quireAccumulator i_quireAccumulator (
    .clk(clk), .arstN(arstN), .accClear(accClear), .convDone(convDone),
    .qValue(qValue), .qNar(qNar), .quire(quire), .nar(nar)
  );

endmodule

//--- include/positRefModel.svh
// Reference posit decode, exact quire value and LFSR step used by the testbench
`ifndef POSITREFMODEL_SVH
`define POSITREFMODEL_SVH

// Fibonacci LFSR with taps 16 14 13 11 that is stepped once per random bit
function automatic logic [15:0] lfsrStep(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// True for the single NaR encoding
function automatic bit isNarWord(input logic [positPkg::PSTWID-1:0] p);
  return p == positPkg::NARWORD;
endfunction

// Split a nonzero, non-NaR posit into sign, signed regime, exponent and fraction
function automatic void decodePosit(
  input  logic [positPkg::PSTWID-1:0]   p,
  output logic                          sgn,
  output int                            regime,
  output int                            expo,
  output logic [positPkg::FRACWID-1:0]  frac
);
  logic [positPkg::PSTWID-1:0] mag;
  logic [positPkg::PSTWID-1:0] rest;
  logic                        runBit;
  int                          k;
  sgn    = p[positPkg::PSTWID-1];
  mag    = sgn ? -p : p;
  runBit = mag[positPkg::PSTWID-2];
  k      = 0;
  while (k < positPkg::PSTWID - 1 && mag[positPkg::PSTWID-2-k] == runBit) begin
    k++;
  end
  regime = runBit ? k - 1 : -k;
  // Missing exponent and fraction bits read as zero after the shift
  rest = mag << (k + 2);
  expo = rest[positPkg::PSTWID-1 -: positPkg::ES];
  frac = rest[positPkg::PSTWID-1-positPkg::ES -: positPkg::FRACWID];
endfunction

// Exact quire image is (1 + fraction) * 2^scale * 2^QFRAC with the sign applied
function automatic logic [quirePkg::QWID-1:0] quireImage(
  input logic [positPkg::PSTWID-1:0] p
);
  logic                         sgn;
  int                           regime;
  int                           expo;
  int                           scale;
  logic [positPkg::FRACWID-1:0] frac;
  logic [quirePkg::QWID-1:0]    q;
  if (p == '0 || isNarWord(p)) begin
    return '0;
  end
  decodePosit(p, sgn, regime, expo, frac);
  scale = regime * (2 ** positPkg::ES) + expo;
  q = {1'b1, frac};
  q = q << (quirePkg::QFRAC - positPkg::FRACWID);
  if (scale >= 0) begin
    q = q << scale;
  end else begin
    q = q >> (-scale);
  end
  return sgn ? -q : q;
endfunction

`endif

//--- verif/tbPositQuire.sv
// Testbench that checks random transactions on the posit to quire unit against a model
`timescale 1ns/1ps

module tbPositQuire;

  `include "positRefModel.svh"

  // Conversion takes at most about a dozen cycles, so this bound is generous
  localparam int ACKLIMIT  = 40;
  localparam int NUMRANDOM = 200;
  localparam int NUMMIXED  = 150;

  logic                         clk = 1'b0;
  logic                         arstN;
  logic                         req;
  logic                         op;
  logic [positPkg::PSTWID-1:0]  posit;
  logic                         ack;
  logic [quirePkg::QWID-1:0]    quire;
  logic                         nar;

  logic [15:0]                  lfsr;
  logic [quirePkg::QWID-1:0]    expQuire;
  logic                         expNar;
  int                           errorCount;
  int                           timeoutCount;

  positQuireTop i_positQuireTop (
    .clk(clk), .arstN(arstN), .req(req), .op(op), .posit(posit),
    .ack(ack), .quire(quire), .nar(nar)
  );

  always #50 clk = ~clk;

  // ==========================================================
  // Helpers
  // ==========================================================

  // Collect n fresh bits with one LFSR step per bit
  function automatic logic [15:0] randBits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      r    = {r[14:0], lfsr[0]};
    end
    return r;
  endfunction

  // Expected quire and flag after one operation
  task automatic updateModel(input logic opIn, input logic [positPkg::PSTWID-1:0] p);
    if (opIn == quirePkg::OPCLEAR) begin
      expQuire = '0;
      expNar   = 1'b0;
    end else if (isNarWord(p)) begin
      // NaR is sticky and leaves the sum alone
      expNar = 1'b1;
    end else begin
      expQuire = expQuire + quireImage(p);
    end
  endtask

  task automatic checkState(input string what);
    if (quire !== expQuire) begin
      errorCount++;
      $display("[ERROR] %0t: %s quire is %h, expected %h", $time, what, quire, expQuire);
    end
    if (nar !== expNar) begin
      errorCount++;
      $display("[ERROR] %0t: %s nar is %b, expected %b", $time, what, nar, expNar);
    end
  endtask

  // One full four-phase handshake with a client stall and an idle gap after it
  task automatic runTransaction(input logic opIn, input logic [positPkg::PSTWID-1:0] p,
                                input int stall, input int gap);
    int                        cnt;
    logic [quirePkg::QWID-1:0] heldQuire;
    @(posedge clk);
    req   <= 1'b1;
    op    <= opIn;
    posit <= p;
    updateModel(opIn, p);
    // Outputs are sampled on the falling edge away from the driving edge
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (!ack && cnt < ACKLIMIT);
    if (!ack) begin
      timeoutCount++;
      $display("Timeout: ack did not rise for posit %h within %0d cycles", p, ACKLIMIT);
    end else begin
      checkState(opIn ? "accumulate" : "clear");
    end
    heldQuire = quire;
    // Holding req must freeze both ack and the sum
    for (int i = 0; i < stall; i++) begin
      @(negedge clk);
      if (!ack) begin
        errorCount++;
        $display("[ERROR] %0t: ack dropped while req was still held", $time);
      end
      if (quire !== heldQuire) begin
        errorCount++;
        $display("[ERROR] %0t: quire changed during a stall", $time);
      end
    end
    @(posedge clk);
    req <= 1'b0;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (ack && cnt < ACKLIMIT);
    if (ack) begin
      timeoutCount++;
      $display("Timeout: ack stayed high for %0d cycles after req fell", ACKLIMIT);
    end
    // With req low, ack must not rise
    for (int i = 0; i < gap; i++) begin
      @(negedge clk);
      if (ack) begin
        errorCount++;
        $display("[ERROR] %0t: ack rose while req was low", $time);
      end
    end
  endtask

  // ==========================================================
  // Test sequence
  // ==========================================================
  initial begin
    logic [positPkg::PSTWID-1:0] edgeVals [$];
    logic [positPkg::PSTWID-1:0] p;
    logic                        opRand;
    arstN        = 1'b0;
    req          = 1'b0;
    op           = quirePkg::OPCLEAR;
    posit        = '0;
    lfsr         = 16'd64735;
    expQuire     = '0;
    expNar       = 1'b0;
    errorCount   = 0;
    timeoutCount = 0;
    repeat (8) @(posedge clk);
    arstN <= 1'b1;

    // Reset state is checked before an explicit clear
    @(negedge clk);
    if (ack !== 1'b0) begin
      errorCount++;
      $display("[ERROR] %0t: ack is %b after reset, expected 0", $time, ack);
    end
    checkState("after reset");
    runTransaction(quirePkg::OPCLEAR, '0, 0, 1);

    // Zero, +-maxpos, +-minpos and +-1
    edgeVals = '{16'h0000, 16'h7FFF, 16'h8001, 16'h0001, 16'hFFFF, 16'h4000, 16'hC000};
    foreach (edgeVals[i]) begin
      runTransaction(quirePkg::OPACCUM, edgeVals[i], i % 3, i % 2);
    end
    runTransaction(quirePkg::OPCLEAR, '0, 0, 0);

    // Random accumulations with random stalls and gaps
    for (int i = 0; i < NUMRANDOM; i++) begin
      p = randBits(16);
      runTransaction(quirePkg::OPACCUM, p, int'(randBits(2)), int'(randBits(2)));
    end
    runTransaction(quirePkg::OPCLEAR, '0, 1, 0);

    // NaR keeps the sum, and the flag survives until a clear
    runTransaction(quirePkg::OPACCUM, 16'h4000, 0, 0);
    runTransaction(quirePkg::OPACCUM, positPkg::NARWORD, 2, 0);
    for (int i = 0; i < 5; i++) begin
      runTransaction(quirePkg::OPACCUM, randBits(16), 0, 1);
    end
    runTransaction(quirePkg::OPCLEAR, '0, 0, 1);

    // Mixed traffic with roughly one clear in eight
    for (int i = 0; i < NUMMIXED; i++) begin
      opRand = (randBits(3) != 0) ? quirePkg::OPACCUM : quirePkg::OPCLEAR;
      p      = randBits(16);
      runTransaction(opRand, p, int'(randBits(3)), int'(randBits(3)));
    end

    @(negedge clk);
    $display("Run complete: %0d value errors, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
verilog/positPkg.sv
verilog/quirePkg.sv
verilog/positDecompose.sv
verilog/positToQuire.sv
verilog/quireAccumulator.sv
verilog/reqAckCtrl.sv
verilog/positQuireTop.sv
verif/tbPositQuire.sv

//--- run.sh
#!/bin/sh
# Build the posit to quire testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module tbPositQuire -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/VtbPositQuire" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

exit 0
